// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - src/isa_pkg.sv
  - src/decode_pkg.sv
  - src/ins_accept.sv
  - src/base_decoder.sv
  - src/rvc_q1_decoder.sv
  - src/decode_hold.sv
  - src/rv_decode_top.sv
  - target: simulation
    files:
      - bench/rv_decode_sva.sv
      - bench/tb_rv_decode.sv

// ==== bench/decode_golden.txt ====
// columns: word op rd rs1 rs2 imm ins_c jump_en, all hex
// op numbers follow op_e, 00 is illegal
123452b7 01 05 08 03 12345000 0 0
fffff317 02 06 1f 1f fffff000 0 0
001000ef 03 01 00 01 00000800 0 1
ff9ff06f 03 00 1f 19 fffffff8 0 1
004280e7 04 01 05 04 00000004 0 0
00310463 05 08 02 03 00000008 0 0
fe311ee3 06 1d 02 03 fffffffc 0 0
00314863 07 10 02 03 00000010 0 0
003150e3 08 01 02 03 00000800 0 0
02316063 09 00 02 03 00000020 0 0
80317063 0a 00 02 03 fffff000 0 0
00312063 00 00 00 00 00000000 0 0
ffc10083 0b 01 02 1c fffffffc 0 0
00811083 0c 01 02 08 00000008 0 0
01012083 0d 01 02 10 00000010 0 0
00114083 0e 01 02 01 00000001 0 0
00215083 0f 01 02 02 00000002 0 0
00310223 10 04 02 03 00000004 0 0
fe311c23 11 18 02 03 fffffff8 0 0
04312023 12 00 02 03 00000040 0 0
fff10093 13 01 02 1f ffffffff 0 0
00512093 14 01 02 05 00000005 0 0
7ff13093 15 01 02 1f 000007ff 0 0
80014093 16 01 02 00 fffff800 0 0
12316093 17 01 02 03 00000123 0 0
0f017093 18 01 02 10 000000f0 0 0
00711093 19 01 02 07 00000007 0 0
01f15093 1a 01 02 1f 0000001f 0 0
40315093 1b 01 02 03 00000003 0 0
003100b3 1c 01 02 03 00000000 0 0
403100b3 1d 01 02 03 00000000 0 0
003110b3 1e 01 02 03 00000000 0 0
003120b3 1f 01 02 03 00000000 0 0
003130b3 20 01 02 03 00000000 0 0
003140b3 21 01 02 03 00000000 0 0
003150b3 22 01 02 03 00000000 0 0
403150b3 23 01 02 03 00000000 0 0
003160b3 24 01 02 03 00000000 0 0
003170b3 25 01 02 03 00000000 0 0
403110b3 00 00 00 00 00000000 0 0
000012f5 13 05 05 00 fffffffd 1 0
00002801 03 01 00 00 00000010 1 1
0000bffd 03 00 00 00 fffffffe 1 1
00008091 1a 09 09 0c 00000004 1 0
00009505 1b 0a 0a 09 00000021 1 0
0000987d 18 08 08 0f ffffffff 1 0
00008c05 1d 08 08 09 00000000 1 0
00008ca9 21 09 09 0a 00000000 1 0
00008fd9 24 0f 0f 0e 00000000 1 0
00008e75 25 0c 0c 0d 00000000 1 0
0000c019 05 00 08 00 00000006 1 0
0000f181 06 00 0b 00 ffffff00 1 0
00006085 00 00 00 00 00000000 1 0
00009c05 00 00 00 00 00000000 1 0
00004008 00 00 00 00 00000000 1 0
00008082 00 00 00 00 00000000 1 0

// ==== bench/rv_decode_sva.sv ====
////////////////////
// handshake and output assertions for the decode stage
////////////////////

module rv_decode_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     ins_req,
    input logic                     ins_ack,
    input decode_pkg::op_e          op,
    input isa_pkg::reg_idx_t        rd,
    input isa_pkg::reg_idx_t        rs1,
    input isa_pkg::reg_idx_t        rs2,
    input logic [isa_pkg::ilen-1:0] imm,
    input logic                     ins_c,
    input logic                     jump_en
);

    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    int fail_count = 0;

    logic [54:0] outs;

    assign outs = {op, rd, rs1, rs2, imm, ins_c, jump_en};

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ins_ack) |-> $past(ins_req))
        else begin
            fail_count++;
            $error("ins_ack rose without a pending request");
        end

    // result frozen while ack is held
    outs_stable: assert property (@(posedge clk) disable iff (rst)
        (ins_ack && $past(ins_ack)) |-> $stable(outs))
        else begin
            fail_count++;
            $error("decode outputs changed while ins_ack was high");
        end

    jump_is_jal: assert property (@(posedge clk) disable iff (rst)
        jump_en |-> (op == op_jal))
        else begin
            fail_count++;
            $error("jump_en set for an operation other than jal");
        end

    ack_low_after_reset: assert property (@(posedge clk)
        rst |=> !ins_ack)
        else begin
            fail_count++;
            $error("ins_ack high in the cycle after reset");
        end

endmodule

bind rv_decode_top rv_decode_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .ins_req (ins_req),
    .ins_ack (ins_ack),
    .op      (op),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .imm     (imm),
    .ins_c   (ins_c),
    .jump_en (jump_en)
);

// ==== bench/tb_rv_decode.sv ====
////////////////////
// testbench for the RV32I / RVC decode stage
// replays the golden vectors over the req/ack handshake
// and checks every decoded field
////////////////////

module tb_rv_decode;

    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    localparam int max_tests = 64;
    localparam int fields    = 8;

    logic        clk;
    logic        rst;
    logic [31:0] ins;
    logic        ins_req;
    logic        ins_ack;
    op_e         op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        ins_c;
    logic        jump_en;

    // word, op, rd, rs1, rs2, imm, ins_c, jump_en per test
    logic [31:0] golden [0:max_tests*fields-1];

    int n_tests      = 0;
    int errors       = 0;
    int test_errors  = 0;
    int failed_tests = 0;
    int cycles       = 0;
    int cycle_limit  = 1000;

    rv_decode_top i_rv_decode_top (
        .clk     (clk),
        .rst     (rst),
        .ins     (ins),
        .ins_req (ins_req),
        .ins_ack (ins_ack),
        .op      (op),
        .rd      (rd),
        .rs1     (rs1),
        .rs2     (rs2),
        .imm     (imm),
        .ins_c   (ins_c),
        .jump_en (jump_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic verify_fields(input int idx);
        int base;
        base = idx * fields;
        check_value("op", op, golden[base+1]);
        check_value("rd", rd, golden[base+2]);
        check_value("rs1", rs1, golden[base+3]);
        check_value("rs2", rs2, golden[base+4]);
        check_value("imm", imm, golden[base+5]);
        check_value("ins_c", ins_c, golden[base+6]);
        check_value("jump_en", jump_en, golden[base+7]);
    endtask

    task automatic report_test(input string label);
        $display("test %s: %s", label, (test_errors == 0) ? "ok" : "error");
        errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
    endtask

    task automatic run_vector(input int idx, input int extra_hold, input string label);
        int          edges;
        logic [31:0] word;
        word        = golden[idx*fields];
        test_errors = 0;
        @(posedge clk);
        #1;
        ins     = word;
        ins_req = 1'b1;
        edges   = 0;
        // ack is due one edge after the edge that samples req
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (!ins_ack && edges < 8);
        if (!ins_ack) begin
            $display("no ack for word %h after %0d cycles", word, edges);
            test_errors++;
        end else begin
            check_value("ack_edges", edges, 2);
            verify_fields(idx);
        end
        // source data only has to stay valid until ack
        ins = ~word;
        // ack and result must not move while req is held
        repeat (extra_hold) begin
            @(posedge clk);
            #1;
            check_value("ins_ack", ins_ack, 1);
            verify_fields(idx);
        end
        ins_req = 1'b0;
        @(posedge clk);
        #1;
        check_value("ins_ack", ins_ack, 0);
        check_value("op", op, golden[idx*fields+1]);
        report_test($sformatf("%s word %h", label, word));
    endtask

    initial begin
        rst     = 1'b1;
        ins     = '0;
        ins_req = 1'b0;
        // unread entries keep an address-derived pattern
        for (int i = 0; i < max_tests * fields; i++) begin
            golden[i] = ~i;
        end
        $readmemh("bench/decode_golden.txt", golden);
        // ins_c column holds 0 or 1 on every line read from the file
        while (n_tests < max_tests && golden[n_tests*fields+6] <= 32'd1) begin
            n_tests++;
        end
        cycle_limit = 40 * n_tests + 100;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_errors = 0;
        check_value("ins_ack", ins_ack, 0);
        check_value("op", op, 0);
        check_value("rd", rd, 0);
        check_value("rs1", rs1, 0);
        check_value("rs2", rs2, 0);
        check_value("imm", imm, 0);
        check_value("ins_c", ins_c, 0);
        check_value("jump_en", jump_en, 0);
        report_test("reset");

        if (n_tests == 0) begin
            $display("golden file holds no test vectors");
            errors++;
        end

        for (int i = 0; i < n_tests; i++) begin
            run_vector(i, 0, $sformatf("%0d", i));
        end
        if (n_tests > 0) begin
            run_vector(0, 5, "hold");
        end

        errors += i_rv_decode_top.u_sva.fail_count;
        $display("%0d vectors, %0d failed tests, %0d errors, %0d assertion failures",
                 n_tests, failed_tests, errors, i_rv_decode_top.u_sva.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/isa_pkg.sv
src/decode_pkg.sv
src/ins_accept.sv
src/base_decoder.sv
src/rvc_q1_decoder.sv
src/decode_hold.sv
src/rv_decode_top.sv
bench/rv_decode_sva.sv
bench/tb_rv_decode.sv

// ==== src/base_decoder.sv ====
////////////////////
// RV32I base decoder
// maps a 32-bit word to operation, register fields
// and a sign-extended immediate
////////////////////

module base_decoder (
    input  isa_pkg::ins_word_u   ins_q,
    output decode_pkg::dec_res_t res
);

    import isa_pkg::*;
    import decode_pkg::*;

    logic [ilen-1:0] w;
    logic [ilen-1:0] imm_i;
    logic [ilen-1:0] imm_s;
    logic [ilen-1:0] imm_b;
    logic [ilen-1:0] imm_u;
    logic [ilen-1:0] imm_j;
    logic [ilen-1:0] imm_sh;
    logic [ilen-1:0] imm;
    logic [2:0]      f3;
    logic            alt;
    op_e             op;

    assign w   = ins_q;
    assign f3  = ins_q.std.funct3;
    // funct7 bit 5 selects sub / sra / srai
    assign alt = ins_q.std.funct7[5];

    ////////////////////
    // immediates by format
    assign imm_i  = {{20{w[31]}}, w[31:20]};
    assign imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    assign imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u  = {w[31:12], 12'b0};
    assign imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    assign imm_sh = {27'b0, w[24:20]};

    always_comb begin
        op  = op_illegal;
        imm = '0;
        case (ins_q.std.opcode)
            opc_lui: begin
                op  = op_lui;
                imm = imm_u;
            end
            opc_auipc: begin
                op  = op_auipc;
                imm = imm_u;
            end
            opc_jal: begin
                op  = op_jal;
                imm = imm_j;
            end
            opc_jalr: begin
                if (f3 == 3'b000) begin
                    op = op_jalr;
                end
                imm = imm_i;
            end
            opc_branch: begin
                imm = imm_b;
                case (f3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_illegal;
                endcase
            end
            opc_load: begin
                imm = imm_i;
                case (f3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    default: op = op_illegal;
                endcase
            end
            opc_store: begin
                imm = imm_s;
                case (f3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    default: op = op_illegal;
                endcase
            end
            opc_op_imm: begin
                imm = imm_i;
                case (f3)
                    3'b000: op = op_addi;
                    3'b010: op = op_slti;
                    3'b011: op = op_sltiu;
                    3'b100: op = op_xori;
                    3'b110: op = op_ori;
                    3'b111: op = op_andi;
                    // shifts carry only the shamt
                    3'b001: begin
                        op  = alt ? op_illegal : op_slli;
                        imm = imm_sh;
                    end
                    3'b101: begin
                        op  = alt ? op_srai : op_srli;
                        imm = imm_sh;
                    end
                endcase
            end
            opc_op: begin
                case ({alt, f3})
                    4'b0000: op = op_add;
                    4'b1000: op = op_sub;
                    4'b0001: op = op_sll;
                    4'b0010: op = op_slt;
                    4'b0011: op = op_sltu;
                    4'b0100: op = op_xor;
                    4'b0101: op = op_srl;
                    4'b1101: op = op_sra;
                    4'b0110: op = op_or;
                    4'b0111: op = op_and;
                    default: op = op_illegal;
                endcase
            end
            default: op = op_illegal;
        endcase
    end

    // illegal words leave every field at zero
    always_comb begin
        res = '0;
        if (op != op_illegal) begin
            res.op   = op;
            res.rd   = ins_q.std.rd;
            res.rs1  = ins_q.std.rs1;
            res.rs2  = ins_q.std.rs2;
            res.imm  = imm;
            res.jump = (op == op_jal);
        end
    end

endmodule

// ==== src/decode_hold.sv ====
////////////////////
// result register
// picks the decoder by quadrant and holds the result
// until the next accepted word
////////////////////

module decode_hold (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  isa_pkg::ins_word_u              ins_q,
    input  decode_pkg::dec_res_t            base_res,
    input  decode_pkg::dec_res_t            rvc_res,
    output decode_pkg::op_e                 op,
    output isa_pkg::reg_idx_t               rd,
    output isa_pkg::reg_idx_t               rs1,
    output isa_pkg::reg_idx_t               rs2,
    output logic [isa_pkg::ilen-1:0]        imm,
    output logic                            ins_c,
    output logic                            jump_en
);

    import isa_pkg::*;
    import decode_pkg::*;

    dec_res_t sel;
    dec_res_t held;

    // quadrants 0 and 2 are not supported
    always_comb begin
        case (ins_q.rvc.quad)
            q_std:   sel = base_res;
            q1:      sel = rvc_res;
            default: begin
                sel      = '0;
                sel.is_c = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (load) begin
            held <= sel;
        end
    end

    assign op      = held.op;
    assign rd      = held.rd;
    assign rs1     = held.rs1;
    assign rs2     = held.rs2;
    assign imm     = held.imm;
    assign ins_c   = held.is_c;
    assign jump_en = held.jump;

endmodule

// ==== src/decode_pkg.sv ====
////////////////////
// decode result definitions
// operation codes and the result word shared by both decoders
////////////////////

package decode_pkg;

    // numbering is fixed, the golden data depends on it
    typedef enum logic [5:0] {
        op_illegal,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and
    } op_e;

    typedef struct packed {
        op_e                      op;
        isa_pkg::reg_idx_t        rd;
        isa_pkg::reg_idx_t        rs1;
        isa_pkg::reg_idx_t        rs2;
        logic [isa_pkg::ilen-1:0] imm;
        logic                     is_c;
        logic                     jump;
    } dec_res_t;

endpackage

// ==== src/ins_accept.sv ====
////////////////////
// instruction accept
// four-phase req/ack controller, latches the incoming word
// and strobes the result register one cycle later
////////////////////

module ins_accept (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [isa_pkg::ilen-1:0] ins,
    input  logic                     ins_req,
    output logic                     ins_ack,
    output isa_pkg::ins_word_u       ins_q,
    output logic                     load
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_busy = 2'd1;
    localparam logic [1:0] st_ack  = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (ins_req) begin
                        state <= st_busy;
                    end
                end
                st_busy: state <= st_ack;
                // hold ack until the source drops req
                st_ack: begin
                    if (!ins_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && ins_req) begin
            ins_q <= ins;
        end
    end

    assign load    = (state == st_busy);
    assign ins_ack = (state == st_ack);

endmodule

// ==== src/isa_pkg.sv ====
////////////////////
// isa definitions for the RV32I decode stage
// standard and compressed views of one instruction word,
// major opcodes and compressed quadrants
////////////////////

package isa_pkg;

    localparam int ilen = 32;

    typedef logic [4:0] reg_idx_t;

    // standard 32-bit layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } std_ins_t;

    // compressed layout, upper half-word ignored
    typedef struct packed {
        logic [15:0] hi;
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  b11_7;
        logic [4:0]  b6_2;
        logic [1:0]  quad;
    } rvc_ins_t;

    typedef union packed {
        std_ins_t std;
        rvc_ins_t rvc;
    } ins_word_u;

    ////////////////////
    // major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // quadrant field, 11 marks a standard word
    localparam logic [1:0] q0    = 2'b00;
    localparam logic [1:0] q1    = 2'b01;
    localparam logic [1:0] q2    = 2'b10;
    localparam logic [1:0] q_std = 2'b11;

endpackage

// ==== src/rv_decode_top.sv ====
////////////////////
// RV32I / RVC decode stage top
// handshake front end, two decoders and the result register
////////////////////

module rv_decode_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [isa_pkg::ilen-1:0] ins,
    input  logic                     ins_req,
    output logic                     ins_ack,
    output decode_pkg::op_e          op,
    output isa_pkg::reg_idx_t        rd,
    output isa_pkg::reg_idx_t        rs1,
    output isa_pkg::reg_idx_t        rs2,
    output logic [isa_pkg::ilen-1:0] imm,
    output logic                     ins_c,
    output logic                     jump_en
);

    import isa_pkg::*;
    import decode_pkg::*;

    ins_word_u ins_q;
    dec_res_t  base_res;
    dec_res_t  rvc_res;
    logic      load;

    ins_accept u_accept (
        .clk     (clk),
        .rst     (rst),
        .ins     (ins),
        .ins_req (ins_req),
        .ins_ack (ins_ack),
        .ins_q   (ins_q),
        .load    (load)
    );

    base_decoder u_base (
        .ins_q (ins_q),
        .res   (base_res)
    );

    rvc_q1_decoder u_rvc (
        .ins_q (ins_q),
        .res   (rvc_res)
    );

    decode_hold u_hold (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .ins_q    (ins_q),
        .base_res (base_res),
        .rvc_res  (rvc_res),
        .op       (op),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm),
        .ins_c    (ins_c),
        .jump_en  (jump_en)
    );

endmodule

// ==== src/rvc_q1_decoder.sv ====
////////////////////
// compressed quadrant 1 decoder
// expands c.jal, c.j, c.addi, the c.alu group and
// c.beqz / c.bnez into their base operations
////////////////////

module rvc_q1_decoder (
    input  isa_pkg::ins_word_u   ins_q,
    output decode_pkg::dec_res_t res
);

    import isa_pkg::*;
    import decode_pkg::*;

    logic [15:0]     h;
    logic [ilen-1:0] imm_ci;
    logic [ilen-1:0] imm_sh;
    logic [ilen-1:0] imm_cj;
    logic [ilen-1:0] imm_cb;
    reg_idx_t        rs1_p;
    reg_idx_t        rs2_p;
    dec_res_t        dec;

    assign h = ins_q[15:0];

    // 3-bit register fields address x8..x15
    assign rs1_p = {2'b01, h[9:7]};
    assign rs2_p = {2'b01, h[4:2]};

    assign imm_ci = {{26{h[12]}}, h[12], h[6:2]};
    assign imm_sh = {26'b0, h[12], h[6:2]};
    assign imm_cj = {{20{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    assign imm_cb = {{23{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};

    always_comb begin
        dec = '0;
        case (ins_q.rvc.funct3)
            3'b000: begin
                dec.op  = op_addi;
                dec.rd  = ins_q.rvc.b11_7;
                dec.rs1 = ins_q.rvc.b11_7;
                dec.imm = imm_ci;
            end
            // c.jal links x1, c.j links x0
            3'b001, 3'b101: begin
                dec.op   = op_jal;
                dec.rd   = ins_q.rvc.funct3[2] ? 5'd0 : 5'd1;
                dec.imm  = imm_cj;
                dec.jump = 1'b1;
            end
            3'b100: begin
                dec.rd  = rs1_p;
                dec.rs1 = rs1_p;
                dec.rs2 = rs2_p;
                case (h[11:10])
                    2'b00: begin
                        dec.op  = op_srli;
                        dec.imm = imm_sh;
                    end
                    2'b01: begin
                        dec.op  = op_srai;
                        dec.imm = imm_sh;
                    end
                    2'b10: begin
                        dec.op  = op_andi;
                        dec.imm = imm_ci;
                    end
                    default: begin
                        if (!ins_q.rvc.b12) begin
                            case (h[6:5])
                                2'b00: dec.op = op_sub;
                                2'b01: dec.op = op_xor;
                                2'b10: dec.op = op_or;
                                2'b11: dec.op = op_and;
                            endcase
                        end
                    end
                endcase
            end
            3'b110, 3'b111: begin
                dec.op  = ins_q.rvc.funct3[0] ? op_bne : op_beq;
                dec.rs1 = rs1_p;
                dec.imm = imm_cb;
            end
            default: dec.op = op_illegal;
        endcase
    end

    always_comb begin
        res      = (dec.op == op_illegal) ? '0 : dec;
        res.is_c = 1'b1;
    end

endmodule
